// ==== verilog.f ====
source/ppm_pkg.sv
source/chip_shift_register.sv
source/ppm16_correlator.sv
source/symbol_timer.sv
source/frame_fsm.sv
source/ppm16_demod.sv
testbench/ppm_clock_gen.sv
testbench/tb_ppm16_demod.sv

// ==== testbench/tb_ppm16_demod.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ppm16_demod;
    import ppm_pkg::*;

    logic    clk;
    logic    gen_resetn;
    logic    scenario_resetn;
    logic    resetn;
    logic    din;
    logic    rx_start;
    chip_t   corr_threshold;
    logic    packet_detected;
    logic    dout_valid;
    symbol_t dout;

    symbol_t expected_q[$];
    int      errors;
    int      timeouts;
    int      detect_count;
    int      valid_count;
    int      seed;
    int      len;

    // Each scenario starts from a cleared window and an idle FSM
    assign resetn = gen_resetn & scenario_resetn;

    ppm_clock_gen u_clock (
        .clk    (clk),
        .resetn (gen_resetn)
    );

    ppm16_demod UUT (
        .clk             (clk),
        .resetn          (resetn),
        .din             (din),
        .rx_start        (rx_start),
        .corr_threshold  (corr_threshold),
        .packet_detected (packet_detected),
        .dout_valid      (dout_valid),
        .dout            (dout)
    );

    // Chip k of the vector is the k-th chip sent
    // Largest chip wins and the earliest one takes a tie
    function automatic symbol_t ref_decode(input logic [WINDOW_BITS-1:0] chips);
        symbol_t pos;
        int      best;
        pos  = '0;
        best = -1;
        for (int k = 0; k < CHIPS_PER_SYMBOL; k++) begin
            if (int'(chips[k*CHIP_BITS +: CHIP_BITS]) > best) begin
                best = int'(chips[k*CHIP_BITS +: CHIP_BITS]);
                pos  = SYMBOL_BITS'(k);
            end
        end
        return pos;
    endfunction

    task automatic send_bit(input logic b);
        @(posedge clk);
        #1 din = b;
    endtask

    task automatic send_silence(input int symbols);
        for (int i = 0; i < symbols * WINDOW_BITS; i++) send_bit(1'b0);
    endtask

    // Pulse chip at value and an optional equal chip at tie_pos
    task automatic send_symbol(input int value, input int pulse, input int noise_max,
                               input int tie_pos, input bit expect_out);
        logic [WINDOW_BITS-1:0] chips;
        chip_t                  c;
        for (int k = 0; k < CHIPS_PER_SYMBOL; k++) begin
            chips[k*CHIP_BITS +: CHIP_BITS] = chip_t'($urandom % (noise_max + 1));
        end
        chips[value*CHIP_BITS +: CHIP_BITS] = chip_t'(pulse);
        if (tie_pos >= 0) chips[tie_pos*CHIP_BITS +: CHIP_BITS] = chip_t'(pulse);
        if (expect_out) expected_q.push_back(ref_decode(chips));
        for (int k = 0; k < CHIPS_PER_SYMBOL; k++) begin
            c = chips[k*CHIP_BITS +: CHIP_BITS];
            for (int b = CHIP_BITS - 1; b >= 0; b--) send_bit(c[b]);
        end
    endtask

    // Noise-free silence, preamble train and delimiter
    task automatic send_lead_in(input int preambles, input int sfd1, input int pulse);
        send_silence(2);
        for (int i = 0; i < preambles; i++) send_symbol(PREAMBLE_SYMBOL, pulse, 0, -1, 0);
        send_symbol(SFD0_SYMBOL, pulse, 0, -1, 0);
        send_symbol(sfd1, pulse, 0, -1, 0);
    endtask

    task automatic send_packet(input int length, input int pulse, input int noise_max,
                               input int tie_index, input bit expect_out);
        int value;
        int tie_pos;
        send_lead_in(8, SFD1_SYMBOL, pulse);
        for (int i = 0; i < HEADER1_SYMBOLS; i++) begin
            send_symbol($urandom % 16, pulse, noise_max, -1, 0);
        end
        for (int i = 0; i < HEADER2_SYMBOLS; i++) begin
            send_symbol((length >> (4 * i)) & 15, pulse, noise_max, -1, 0);
        end
        for (int i = 0; i <= length; i++) begin
            value   = $urandom % 16;
            tie_pos = (i == tie_index) ? (value + 1 + $urandom % 15) % 16 : -1;
            send_symbol(value, pulse, noise_max, tie_pos, expect_out);
        end
        send_bit(1'b0);
    endtask

    task automatic restart(input logic start, input chip_t threshold);
        @(posedge clk);
        #1;
        scenario_resetn = 1'b0;
        din             = 1'b0;
        rx_start        = start;
        corr_threshold  = threshold;
        expected_q.delete();
        repeat (2) @(posedge clk);
        #1 scenario_resetn = 1'b1;
        detect_count = 0;
        valid_count  = 0;
    endtask

    task automatic check_packet(input int length);
        int cycles;
        cycles = 0;
        while (expected_q.size() > 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() > 0) begin
            timeouts++;
            $display("Timeout: %0d data symbols never appeared", expected_q.size());
        end
        // A surplus word would come one symbol after the last one
        repeat (WINDOW_BITS + 2) @(posedge clk);
        assert (detect_count == 1 && valid_count == length + 1) else begin
            errors++;
            $display("CHECK FAILED @ %0t: %0d detects and %0d words, expected 1 and %0d",
                     $time, detect_count, valid_count, length + 1);
        end
    endtask

    task automatic check_silent(input int cycles);
        for (int i = 0; i < cycles; i++) @(posedge clk);
        assert (detect_count == 0 && valid_count == 0) else begin
            errors++;
            $display("CHECK FAILED @ %0t: output from a frame that must be ignored", $time);
        end
    endtask

    // Compare every strobe with the reference queue
    always @(negedge clk) begin : compare_outputs
        symbol_t exp_sym;
        if (resetn && packet_detected) detect_count++;
        if (resetn && dout_valid) begin
            valid_count++;
            assert (detect_count == 1) else begin
                errors++;
                $display("CHECK FAILED @ %0t: dout_valid without a packet_detected", $time);
            end
            assert (expected_q.size() > 0) else begin
                errors++;
                $display("CHECK FAILED @ %0t: unexpected dout_valid", $time);
            end
            if (expected_q.size() > 0) begin
                exp_sym = expected_q.pop_front();
                assert (dout == exp_sym) else begin
                    errors++;
                    $display("CHECK FAILED @ %0t: dout %0d expected %0d", $time, dout, exp_sym);
                end
            end
        end
    end

    initial begin : stimulus
        int n;
        din             = 1'b0;
        rx_start        = 1'b0;
        corr_threshold  = chip_t'(3);
        scenario_resetn = 1'b1;
        errors          = 0;
        timeouts        = 0;
        detect_count    = 0;
        valid_count     = 0;
        seed            = 33;
        void'($urandom(seed));
        n = 0;
        while (gen_resetn !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (gen_resetn !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end

        // Random packets
        for (int p = 0; p < 6; p++) begin
            restart(1'b1, chip_t'(3));
            len = $urandom % 8;
            send_packet(len, 3, 1, -1, 1);
            check_packet(len);
        end

        // Equal peak on a second chip
        restart(1'b1, chip_t'(3));
        send_packet(5, 3, 1, 2, 1);
        check_packet(5);

        // Wrong SFD1, then a good packet
        restart(1'b1, chip_t'(3));
        send_lead_in(8, 3, 3);
        send_packet(4, 3, 1, -1, 1);
        check_packet(4);

        // Too short a preamble, then a good packet
        restart(1'b1, chip_t'(3));
        send_lead_in(3, SFD1_SYMBOL, 3);
        send_packet(3, 3, 1, -1, 1);
        check_packet(3);

        // Weak pulses stay under the threshold
        restart(1'b1, chip_t'(3));
        send_packet(2, 2, 0, -1, 0);
        check_silent(50);
        send_packet(6, 3, 1, -1, 1);
        check_packet(6);

        // Receiver not started
        restart(1'b0, chip_t'(3));
        send_packet(2, 3, 1, -1, 0);
        check_silent(50);

        $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/ppm_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppm_clock_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for two rising edges
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/ppm16_demod.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppm16_demod (
    input  logic             clk,
    input  logic             resetn,
    input  logic             din,
    input  logic             rx_start,
    input  ppm_pkg::chip_t   corr_threshold,
    output logic             packet_detected,
    output logic             dout_valid,
    output ppm_pkg::symbol_t dout
);
    import ppm_pkg::*;

    logic [WINDOW_BITS-1:0] window;
    logic                   shift_en;
    logic                   threshold_unmet;
    logic                   timer_run;
    logic                   symbol_end;

    chip_shift_register u_shift (
        .clk      (clk),
        .resetn   (resetn),
        .shift_en (shift_en),
        .din      (din),
        .window   (window)
    );

    // Symbol is valid only on the dout_valid strobe
    ppm16_correlator u_correlator (
        .window          (window),
        .threshold       (corr_threshold),
        .symbol          (dout),
        .threshold_unmet (threshold_unmet)
    );

    symbol_timer u_timer (
        .clk        (clk),
        .resetn     (resetn),
        .timer_run  (timer_run),
        .symbol_end (symbol_end)
    );

    frame_fsm u_fsm (
        .clk             (clk),
        .resetn          (resetn),
        .rx_start        (rx_start),
        .symbol          (dout),
        .threshold_unmet (threshold_unmet),
        .symbol_end      (symbol_end),
        .shift_en        (shift_en),
        .timer_run       (timer_run),
        .packet_detected (packet_detected),
        .dout_valid      (dout_valid)
    );

endmodule

`default_nettype wire

// ==== source/frame_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_fsm (
    input  logic             clk,
    input  logic             resetn,
    input  logic             rx_start,
    input  ppm_pkg::symbol_t symbol,
    input  logic             threshold_unmet,
    input  logic             symbol_end,
    output logic             shift_en,
    output logic             timer_run,
    output logic             packet_detected,
    output logic             dout_valid
);
    import ppm_pkg::*;

    demod_state_t state;
    demod_state_t next_state;

    logic [PREAMBLE_COUNT_BITS-1:0] preamble_count;
    logic [HEADER1_COUNT_BITS-1:0]  header1_count;
    logic [HEADER2_COUNT_BITS-1:0]  header2_count;
    logic [LENGTH_BITS-1:0]         data_count;
    logic [LENGTH_BITS-1:0]         length_q;

    logic preamble_done;
    logic header1_done;
    logic header2_done;
    logic data_done;

    assign preamble_done = (preamble_count == PREAMBLE_COUNT_BITS'(PREAMBLE_MIN_SYMBOLS));
    assign header1_done  = (header1_count == HEADER1_COUNT_BITS'(HEADER1_SYMBOLS - 1));
    assign header2_done  = (header2_count == HEADER2_COUNT_BITS'(HEADER2_SYMBOLS - 1));
    assign data_done     = (data_count == length_q);

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (rx_start) next_state = S_SCAN;
            end
            // Bit-by-bit search applies the threshold
            S_SCAN: begin
                if (!rx_start) begin
                    next_state = S_IDLE;
                end else if (symbol == PREAMBLE_SYMBOL && !threshold_unmet) begin
                    next_state = S_PREAMBLE;
                end
            end
            S_PREAMBLE: begin
                if (symbol_end) begin
                    if (symbol == PREAMBLE_SYMBOL) begin
                        next_state = S_PREAMBLE;
                    end else if (symbol == SFD0_SYMBOL && preamble_done) begin
                        next_state = S_SFD;
                    end else begin
                        next_state = S_SCAN;
                    end
                end
            end
            S_SFD: begin
                if (symbol_end) begin
                    next_state = (symbol == SFD1_SYMBOL) ? S_HEADER1 : S_SCAN;
                end
            end
            S_HEADER1: begin
                if (symbol_end && header1_done) next_state = S_HEADER2;
            end
            S_HEADER2: begin
                if (symbol_end && header2_done) next_state = S_DATA;
            end
            S_DATA: begin
                if (symbol_end && data_done) next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Field counters run only in their own state
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            preamble_count <= '0;
            header1_count  <= '0;
            header2_count  <= '0;
            data_count     <= '0;
        end else begin
            if (state != S_PREAMBLE) begin
                preamble_count <= '0;
            end else if (symbol_end && symbol == PREAMBLE_SYMBOL && !preamble_done) begin
                preamble_count <= preamble_count + 1'b1;
            end
            if (state != S_HEADER1) header1_count <= '0;
            else if (symbol_end) header1_count <= header1_count + 1'b1;
            if (state != S_HEADER2) header2_count <= '0;
            else if (symbol_end) header2_count <= header2_count + 1'b1;
            if (state != S_DATA) data_count <= '0;
            else if (symbol_end) data_count <= data_count + 1'b1;
        end
    end

    // Length arrives least significant nibble first
    always_ff @(posedge clk) begin
        if (state == S_HEADER2 && symbol_end) begin
            length_q[header2_count * SYMBOL_BITS +: SYMBOL_BITS] <= symbol;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            packet_detected <= 1'b0;
        end else begin
            packet_detected <= (state == S_HEADER2) && (next_state == S_DATA);
        end
    end

    assign shift_en   = (state != S_IDLE);
    assign timer_run  = (state != S_IDLE) && (state != S_SCAN);
    assign dout_valid = (state == S_DATA) && symbol_end;

    a_valid_in_data : assert property (@(posedge clk) disable iff (!resetn)
        dout_valid |-> (state == S_DATA) && (data_count <= length_q));

    // First data cycle carries no word yet
    a_detect_on_entry : assert property (@(posedge clk) disable iff (!resetn)
        packet_detected |-> (state == S_DATA) && !dout_valid);

endmodule

`default_nettype wire

// ==== source/symbol_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module symbol_timer (
    input  logic clk,
    input  logic resetn,
    input  logic timer_run,
    output logic symbol_end
);
    import ppm_pkg::*;

    logic [CHIP_COUNT_BITS-1:0] bit_count;
    logic [SYMBOL_BITS-1:0]     chip_count;
    logic                       bit_max;
    logic                       chip_max;

    assign bit_max  = (bit_count == CHIP_COUNT_BITS'(CHIP_BITS - 1));
    assign chip_max = (chip_count == SYMBOL_BITS'(CHIPS_PER_SYMBOL - 1));

    // Bit within the current chip
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            bit_count <= '0;
        end else if (!timer_run || bit_max) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // Chip within the current symbol
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            chip_count <= '0;
        end else if (!timer_run) begin
            chip_count <= '0;
        end else if (bit_max) begin
            chip_count <= chip_max ? '0 : chip_count + 1'b1;
        end
    end

    // Last bit of an aligned symbol is in the window
    assign symbol_end = bit_max && chip_max;

    // Counters start from zero when the FSM locks, so no boundary before that
    a_no_end_when_idle : assert property (@(posedge clk) disable iff (!resetn)
        $rose(symbol_end) |-> timer_run);

endmodule

`default_nettype wire

// ==== source/ppm16_correlator.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppm16_correlator (
    input  logic [ppm_pkg::WINDOW_BITS-1:0] window,
    input  ppm_pkg::chip_t                  threshold,
    output ppm_pkg::symbol_t                symbol,
    output logic                            threshold_unmet
);
    import ppm_pkg::*;

    // Chips in the order they were sent, first chip at position 0
    chip_t chips [CHIPS_PER_SYMBOL];
    chip_t peak;

    always_comb begin
        for (int k = 0; k < CHIPS_PER_SYMBOL; k++) begin
            chips[k] = window[(CHIPS_PER_SYMBOL - 1 - k) * CHIP_BITS +: CHIP_BITS];
        end
    end

    // Strict compare keeps the earliest chip on a tie
    always_comb begin
        chip_t   best;
        symbol_t best_pos;
        best     = chips[0];
        best_pos = '0;
        for (int k = 1; k < CHIPS_PER_SYMBOL; k++) begin
            if (chips[k] > best) begin
                best     = chips[k];
                best_pos = SYMBOL_BITS'(k);
            end
        end
        peak   = best;
        symbol = best_pos;
    end

    assign threshold_unmet = (peak < threshold);

endmodule

`default_nettype wire

// ==== source/chip_shift_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module chip_shift_register (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            shift_en,
    input  logic                            din,
    output logic [ppm_pkg::WINDOW_BITS-1:0] window
);
    import ppm_pkg::*;

    // Newest bit enters at bit 0, so chip 15 holds the first chip sent
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            window <= '0;
        end else if (shift_en) begin
            window <= {window[WINDOW_BITS-2:0], din};
        end
    end

endmodule

`default_nettype wire

// ==== source/ppm_pkg.sv ====
`default_nettype none

package ppm_pkg;

    // Link framing
    localparam int CHIP_BITS            = 2;
    localparam int CHIPS_PER_SYMBOL     = 16;
    localparam int WINDOW_BITS          = CHIP_BITS * CHIPS_PER_SYMBOL;
    localparam int SYMBOL_BITS          = 4;
    localparam int CHIP_COUNT_BITS      = (CHIP_BITS > 1) ? $clog2(CHIP_BITS) : 1;

    // Field lengths in symbols
    localparam int PREAMBLE_MIN_SYMBOLS = 4;
    localparam int HEADER1_SYMBOLS      = 8;
    localparam int HEADER2_SYMBOLS      = 4;
    localparam int LENGTH_BITS          = 16;

    // Widths of the per-field symbol counters
    localparam int PREAMBLE_COUNT_BITS  = $clog2(PREAMBLE_MIN_SYMBOLS + 1);
    localparam int HEADER1_COUNT_BITS   = $clog2(HEADER1_SYMBOLS);
    localparam int HEADER2_COUNT_BITS   = $clog2(HEADER2_SYMBOLS);

    typedef logic [CHIP_BITS-1:0]   chip_t;
    typedef logic [SYMBOL_BITS-1:0] symbol_t;

    // Symbol values that mark the frame start
    localparam symbol_t PREAMBLE_SYMBOL = 4'd0;
    localparam symbol_t SFD0_SYMBOL     = 4'd10;
    localparam symbol_t SFD1_SYMBOL     = 4'd5;

    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,
        S_SCAN     = 3'd1,
        S_PREAMBLE = 3'd2,
        S_SFD      = 3'd3,
        S_HEADER1  = 3'd4,
        S_HEADER2  = 3'd5,
        S_DATA     = 3'd6
    } demod_state_t;

endpackage

`default_nettype wire
